// File: dv/tb_clock.sv
// ################################################
// Free-running testbench clock, 100 ns period.
// ################################################

module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial clk_o = 1'b0;

    always #50 clk_o = ~clk_o;  // half period

endmodule

// File: dv/token_engine_checker.sv
// ################################################
// Concurrent assertions on the GLB port, ifmap
// push strobes and the done pulse of the engine.
// Attached to every token_engine by bind.
// ################################################

module token_engine_checker (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic                        glb_read_i,
    input logic [token_pkg::WEB_W-1:0] glb_web_i,
    input token_pkg::fifo_mask_t       push_i,
    input logic                        pass_done_i
);

    timeunit 1ns;
    timeprecision 1ps;

    web_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        (glb_web_i == token_pkg::WEB_IDLE) || (glb_web_i == token_pkg::WEB_WORD))
        else $error("GLB write enable has an illegal encoding");

    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(glb_read_i && (glb_web_i == token_pkg::WEB_WORD)))
        else $error("GLB read and write issued in the same cycle");

    push_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(push_i))
        else $error("more than one ifmap FIFO pushed at once");

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        pass_done_i |=> !pass_done_i)
        else $error("pass_done_o held longer than one cycle");

endmodule

bind token_engine token_engine_checker u_checker (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .glb_read_i  (glb_read_o),
    .glb_web_i   (glb_web_o),
    .push_i      (ifmap_push_o.push),
    .pass_done_i (pass_done_o)
);

// File: dv/token_engine_tb.sv
// ################################################
// Directed testbench for the token engine. Models
// the GLB memory, ifmap and opsum FIFOs, keeps
// expected queues and prints the final verdict.
// ################################################

module token_engine_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IFMAP_DEPTH = 8;
    localparam int TIMEOUT     = 2000;  // cycles per wait

    logic                          clk;
    logic                          rst_n;
    logic                          pass_start;
    token_pkg::pass_cfg_t          cfg;
    logic                          pass_done;
    logic                          glb_read;
    logic [token_pkg::WEB_W-1:0]   glb_web;
    logic [token_pkg::ADDR_W-1:0]  glb_addr;
    logic [token_pkg::DATA_W-1:0]  glb_wdata;
    logic [token_pkg::DATA_W-1:0]  glb_rdata;
    token_pkg::fifo_mask_t         ifmap_full;
    token_pkg::push_t              ifmap_push;
    token_pkg::fifo_mask_t         opsum_empty;
    logic [token_pkg::DATA_W-1:0]  opsum_head [token_pkg::NUM_FIFO];
    token_pkg::fifo_mask_t         opsum_pop;

    token_pkg::fifo_mask_t         hold_full;
    token_pkg::fifo_mask_t         hold_empty;
    token_pkg::fifo_mask_t         opsum_has;   // one word per opsum FIFO
    int                            fill [token_pkg::NUM_FIFO];

    token_pkg::push_t              exp_push [$];
    logic [token_pkg::ADDR_W-1:0]  exp_rd [$];
    logic [token_pkg::ADDR_W-1:0]  exp_wr_addr [$];
    logic [token_pkg::DATA_W-1:0]  exp_wr_data [$];

    int          chk_errs;
    int          proto_errs;
    int          tmo_errs;
    logic [31:0] lfsr_state;

    tb_clock u_clock (.clk_o(clk));

    token_engine i_token_engine (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .pass_start_i     (pass_start),
        .cfg_i            (cfg),
        .pass_done_o      (pass_done),
        .glb_read_o       (glb_read),
        .glb_web_o        (glb_web),
        .glb_addr_o       (glb_addr),
        .glb_write_data_o (glb_wdata),
        .glb_read_data_i  (glb_rdata),
        .ifmap_full_i     (ifmap_full),
        .ifmap_push_o     (ifmap_push),
        .opsum_empty_i    (opsum_empty),
        .opsum_pop_data_i (opsum_head),
        .opsum_pop_o      (opsum_pop)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] next_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return w;
    endfunction

    // scale, clamp to int8, optional relu
    function automatic logic [31:0] ppu_expect(logic [31:0] w, token_pkg::pass_cfg_t c);
        logic signed [31:0] s;
        if (!c.need_ppu) return w;
        s = $signed(w) >>> c.scaling;
        if (s > 127) s = 127;
        else if (s < -128) s = -128;
        if (c.relu_en && s < 0) s = 0;
        return s;
    endfunction

    function automatic token_pkg::pass_cfg_t make_cfg(logic [31:0] ifb, logic [31:0] opb,
            logic [7:0] words, logic [2:0] ic, logic [2:0] oc, logic [5:0] scl,
            logic relu, logic ppu_on);
        token_pkg::pass_cfg_t c;
        c.ifmap_base  = ifb;
        c.opsum_base  = opb;
        c.ifmap_words = words;
        c.ic_real     = ic;
        c.oc_real     = oc;
        c.scaling     = scl;
        c.relu_en     = relu;
        c.need_ppu    = ppu_on;
        return c;
    endfunction

    task automatic check_push(input token_pkg::push_t got, input token_pkg::push_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: ifmap push mask %b data %h, expected %b data %h",
                     $time, got.push, got.data, exp.push, exp.data);
            chk_errs++;
        end
    endtask

    task automatic check_write(input logic [token_pkg::ADDR_W-1:0] got_addr,
                               input logic [token_pkg::ADDR_W-1:0] exp_addr,
                               input logic [token_pkg::DATA_W-1:0] got_data,
                               input logic [token_pkg::DATA_W-1:0] exp_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("CHECK FAILED at %0t: GLB write %h <= %h, expected %h <= %h",
                     $time, got_addr, got_data, exp_addr, exp_data);
            chk_errs++;
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            chk_errs++;
        end
    endtask

    // glb memory with read data one cycle after the strobe
    always @(posedge clk) begin
        if (glb_read) glb_rdata <= glb_addr ^ 32'h5a5a0000;
    end

    always_comb begin
        for (int f = 0; f < token_pkg::NUM_FIFO; f++) begin
            ifmap_full[f]  = hold_full[f] || (fill[f] >= IFMAP_DEPTH - 2);  // almost full
            opsum_empty[f] = !opsum_has[f] || hold_empty[f];
        end
    end

    // fifo and port monitors
    always @(posedge clk) begin
        if (rst_n) begin
            if (ifmap_push.push != '0) begin
                if (exp_push.size() == 0) begin
                    $display("unexpected ifmap push, mask %b at %0t", ifmap_push.push, $time);
                    proto_errs++;
                end else begin
                    check_push(ifmap_push, exp_push.pop_front());
                end
            end
            if ((ifmap_push.push & hold_full) != '0) begin
                $display("ifmap FIFO pushed while held full, mask %b at %0t",
                         ifmap_push.push, $time);
                proto_errs++;
            end
            for (int f = 0; f < token_pkg::NUM_FIFO; f++) begin
                if (ifmap_push.push[f]) fill[f] <= fill[f] + 1;
                if (opsum_pop[f]) begin
                    if (opsum_empty[f] || f >= int'(cfg.oc_real)) begin
                        $display("opsum FIFO %0d popped while empty or inactive", f);
                        proto_errs++;
                    end
                    opsum_has[f] <= 1'b0;
                end
            end
            if (glb_read) begin
                if (exp_rd.size() == 0) begin
                    $display("unexpected GLB read of %h at %0t", glb_addr, $time);
                    proto_errs++;
                end else begin
                    check_word(glb_addr, exp_rd.pop_front(), "GLB read address");
                end
            end
            if (glb_web == token_pkg::WEB_WORD) begin
                if (exp_wr_addr.size() == 0) begin
                    $display("unexpected GLB write to %h at %0t", glb_addr, $time);
                    proto_errs++;
                end else begin
                    check_write(glb_addr, exp_wr_addr.pop_front(), glb_wdata,
                                exp_wr_data.pop_front());
                end
            end
        end
    end

    // one pass with expected traffic and holds released after hold_cycles
    task automatic run_pass(input token_pkg::pass_cfg_t c, input token_pkg::fifo_mask_t fh,
                            input token_pkg::fifo_mask_t eh, input int hold_cycles);
        token_pkg::push_t      p;
        token_pkg::fifo_mask_t active;
        logic [31:0]           addr;
        logic [31:0]           w;
        int                    cyc;
        bit                    seen;
        active = token_pkg::fifo_mask_t'((1 << int'(c.oc_real)) - 1);
        for (int f = 0; f < int'(c.ic_real); f++) begin
            for (int k = 0; k < int'(c.ifmap_words); k++) begin
                addr = (c.ifmap_base + 32'(f) * 32'(c.ifmap_words) + 32'(k)) << 2;
                p.push = token_pkg::fifo_mask_t'(1 << f);
                p.data = addr ^ 32'h5a5a0000;
                exp_rd.push_back(addr);
                exp_push.push_back(p);
            end
        end
        @(posedge clk);
        for (int f = 0; f < token_pkg::NUM_FIFO; f++) begin
            w = next_word();
            opsum_head[f] <= w;
            fill[f]       <= 0;
            if (f < int'(c.oc_real)) begin
                exp_wr_addr.push_back((c.opsum_base + 32'(f)) << 2);
                exp_wr_data.push_back(ppu_expect(w, c));
            end
        end
        opsum_has  <= '1;  // inactive FIFOs hold data too
        cfg        <= c;
        hold_full  <= fh;
        hold_empty <= eh;
        @(posedge clk);
        pass_start <= 1'b1;
        @(posedge clk);
        pass_start <= 1'b0;
        cyc  = 0;
        seen = 0;
        while (!seen && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
            if (cyc == hold_cycles) begin
                hold_full  <= '0;
                hold_empty <= '0;
            end
            @(negedge clk);
            seen = pass_done;
        end
        if (!seen) begin
            $display("timeout: pass_done_o did not arrive within %0d cycles", TIMEOUT);
            tmo_errs++;
        end else begin
            check_word(32'(exp_push.size()), 0, "pushes missing at pass end");
            check_word(32'(exp_rd.size()), 0, "reads missing at pass end");
            check_word(32'(exp_wr_addr.size()), 0, "writes missing at pass end");
            check_word(32'(opsum_has & active), 0, "active opsum FIFOs left unpopped");
        end
        exp_push.delete();
        exp_rd.delete();
        exp_wr_addr.delete();
        exp_wr_data.delete();
        @(posedge clk);
    endtask

    task automatic reset_and_idle();
        @(negedge clk);
        check_word(32'(glb_read), 0, "glb_read_o after reset");
        check_word(32'(glb_web), 32'(token_pkg::WEB_IDLE), "glb_web_o after reset");
        check_word(32'(ifmap_push.push), 0, "ifmap push after reset");
        check_word(32'(opsum_pop), 0, "opsum pop after reset");
        repeat (5) begin
            @(negedge clk);
            check_word(32'(pass_done), 0, "pass_done_o without start");
        end
        run_pass(make_cfg(32'h40, 32'h80, 8'd3, 3'd0, 3'd0, 6'd0, 1'b0, 1'b0), '0, '0, 0);
    endtask

    task automatic fetch_routing();
        run_pass(make_cfg(32'h100, 32'h0, 8'd4, 3'd3, 3'd0, 6'd0, 1'b0, 1'b0), '0, '0, 0);
        run_pass(make_cfg(32'h3f0, 32'h0, 8'd6, 3'd4, 3'd0, 6'd0, 1'b0, 1'b0), '0, '0, 0);
    endtask

    task automatic drain_raw();
        run_pass(make_cfg(32'h0, 32'h2000, 8'd0, 3'd0, 3'd3, 6'd0, 1'b0, 1'b0), '0, '0, 0);
    endtask

    task automatic ppu_shaping();
        run_pass(make_cfg(32'h0, 32'h2100, 8'd0, 3'd0, 3'd4, 6'd20, 1'b0, 1'b1), '0, '0, 0);
        run_pass(make_cfg(32'h0, 32'h2200, 8'd0, 3'd0, 3'd4, 6'd24, 1'b0, 1'b1), '0, '0, 0);
        run_pass(make_cfg(32'h0, 32'h2300, 8'd0, 3'd0, 3'd4, 6'd22, 1'b1, 1'b1), '0, '0, 0);
    endtask

    // fifo 1 stays full and opsum fifo 0 empty for a while
    task automatic backpressure();
        run_pass(make_cfg(32'h500, 32'h3000, 8'd5, 3'd4, 3'd4, 6'd21, 1'b1, 1'b1),
                 4'b0010, 4'b0001, 40);
    endtask

    initial begin
        rst_n      = 1'b0;
        pass_start = 1'b0;
        cfg        = '0;
        glb_rdata  = '0;
        hold_full  = '0;
        hold_empty = '0;
        opsum_has  = '0;
        lfsr_state = 32'hf6ad362b;
        chk_errs   = 0;
        proto_errs = 0;
        tmo_errs   = 0;
        for (int f = 0; f < token_pkg::NUM_FIFO; f++) begin
            fill[f]       = 0;
            opsum_head[f] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_idle();
        fetch_routing();
        drain_raw();
        ppu_shaping();
        backpressure();
        $display("errors: %0d value, %0d protocol, %0d timeout", chk_errs, proto_errs, tmo_errs);
        if (chk_errs + proto_errs + tmo_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the token engine testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module token_engine_tb -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "sim passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: src/engine_ctrl.sv
// ################################################
// Pass sequencer. A start pulse opens the pass,
// both channels run until their done flags are
// high, then a single-cycle done pulse is given.
// ################################################

module engine_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic pass_start_i,
    input  logic fetch_done_i,
    input  logic drain_done_i,
    output logic run_o,
    output logic pass_done_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pass_start_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // both channels finished their share
                if (fetch_done_i && drain_done_i) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;  // one cycle only
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign run_o       = (state_q == RUN);
    assign pass_done_o = (state_q == DONE);

endmodule

// File: src/glb_arbiter.sv
// ################################################
// GLB port arbiter. Grants one request per cycle,
// drain writes before fetch reads, and registers
// the granted command onto the GLB port.
// ################################################

module glb_arbiter (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  token_pkg::glb_req_t            rd_req_i,
    input  token_pkg::glb_req_t            wr_req_i,
    output logic                           rd_grant_o,
    output logic                           wr_grant_o,
    output logic                           glb_read_o,
    output logic [token_pkg::WEB_W-1:0]    glb_web_o,
    output logic [token_pkg::ADDR_W-1:0]   glb_addr_o,
    output logic [token_pkg::DATA_W-1:0]   wr_data_o
);

    // write has priority
    assign wr_grant_o = wr_req_i.valid;
    assign rd_grant_o = rd_req_i.valid && !wr_req_i.valid;

    // command strobes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            glb_read_o <= 1'b0;
            glb_web_o  <= token_pkg::WEB_IDLE;
        end else begin
            glb_read_o <= rd_grant_o;
            glb_web_o  <= wr_grant_o ? token_pkg::WEB_WORD : token_pkg::WEB_IDLE;
        end
    end

    // address and data only move on a grant
    always_ff @(posedge clk) begin
        if (wr_grant_o) begin
            glb_addr_o <= wr_req_i.addr;
            wr_data_o  <= wr_req_i.wdata;
        end else if (rd_grant_o) begin
            glb_addr_o <= rd_req_i.addr;
        end
    end

endmodule

// File: src/ifmap_fetch.sv
// ################################################
// Ifmap fetch channel. Reads ifmap_words words per
// active ifmap FIFO from the GLB and pushes each
// returned word two cycles after its grant.
// ################################################

module ifmap_fetch (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           run_i,
    input  token_pkg::pass_cfg_t           cfg_i,
    input  token_pkg::fifo_mask_t          full_i,
    input  logic                           grant_i,
    input  logic [token_pkg::DATA_W-1:0]   read_data_i,
    output token_pkg::glb_req_t            req_o,
    output token_pkg::push_t               push_o,
    output logic                           done_o
);

    logic [token_pkg::FIFO_IDX_W-1:0] fifo_q;     // current FIFO f
    logic [7:0]                       word_q;     // word k within FIFO
    logic [token_pkg::ADDR_W-1:0]     offset_q;   // f*ifmap_words + k
    logic                             issued_q;   // all reads granted
    logic                             no_work;
    logic                             last_word;
    logic                             last_fifo;

    // read return pipe, [0] granted last cycle, [1] data arrives now
    logic [1:0]                       rd_vld_q;
    logic [token_pkg::FIFO_IDX_W-1:0] rd_idx_q [2];

    assign no_work   = (cfg_i.ic_real == 3'd0) || (cfg_i.ifmap_words == 8'd0);
    assign last_word = (word_q == cfg_i.ifmap_words - 8'd1);
    assign last_fifo = ({1'b0, fifo_q} == cfg_i.ic_real - 3'd1);

    always_comb begin
        req_o.valid = run_i && !no_work && !issued_q && !full_i[fifo_q];
        req_o.addr  = (cfg_i.ifmap_base + offset_q) << token_pkg::BYTE_SHIFT;
        req_o.wdata = '0;  // reads carry no data
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fifo_q   <= '0;
            word_q   <= '0;
            offset_q <= '0;
            issued_q <= 1'b0;
            rd_vld_q <= '0;
        end else if (!run_i) begin
            fifo_q   <= '0;
            word_q   <= '0;
            offset_q <= '0;
            issued_q <= 1'b0;
            rd_vld_q <= '0;
        end else begin
            rd_vld_q <= {rd_vld_q[0], grant_i};
            if (grant_i) begin
                offset_q <= offset_q + 1'b1;
                if (last_word) begin
                    word_q <= '0;
                    if (last_fifo) begin
                        issued_q <= 1'b1;
                    end else begin
                        fifo_q <= fifo_q + 1'b1;
                    end
                end else begin
                    word_q <= word_q + 8'd1;
                end
            end
        end
    end

    // index travels with the read
    always_ff @(posedge clk) begin
        rd_idx_q[0] <= fifo_q;
        rd_idx_q[1] <= rd_idx_q[0];
    end

    always_comb begin
        push_o.push = rd_vld_q[1] ? (token_pkg::fifo_mask_t'(1'b1) << rd_idx_q[1]) : '0;
        push_o.data = read_data_i;  // GLB data valid this cycle
    end

    // nothing left to issue and nothing in flight
    assign done_o = run_i && (no_work || (issued_q && (rd_vld_q == 2'b00)));

endmodule

// File: src/opsum_drain.sv
// ################################################
// Opsum drain channel. Pops one head word from each
// active opsum FIFO and offers it as a GLB write
// to opsum_base + f. Pop happens in the grant cycle.
// ################################################

module opsum_drain (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           run_i,
    input  token_pkg::pass_cfg_t           cfg_i,
    input  token_pkg::fifo_mask_t          empty_i,
    input  logic [token_pkg::DATA_W-1:0]   pop_data_i [token_pkg::NUM_FIFO],
    input  logic                           grant_i,
    output token_pkg::glb_req_t            req_o,
    output token_pkg::fifo_mask_t          pop_o,
    output logic                           done_o
);

    logic [token_pkg::FIFO_IDX_W-1:0] fifo_q;
    logic                             issued_q;  // every active FIFO written
    logic                             no_work;
    logic [token_pkg::ADDR_W-1:0]     fifo_off;

    assign no_work  = (cfg_i.oc_real == 3'd0);
    assign fifo_off = {{(token_pkg::ADDR_W-token_pkg::FIFO_IDX_W){1'b0}}, fifo_q};

    always_comb begin
        req_o.valid = run_i && !no_work && !issued_q && !empty_i[fifo_q];
        req_o.addr  = (cfg_i.opsum_base + fifo_off) << token_pkg::BYTE_SHIFT;
        req_o.wdata = pop_data_i[fifo_q];  // fall-through head word
    end

    // head word leaves the FIFO when the write is taken
    assign pop_o = grant_i ? (token_pkg::fifo_mask_t'(1'b1) << fifo_q) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fifo_q   <= '0;
            issued_q <= 1'b0;
        end else if (!run_i) begin
            fifo_q   <= '0;
            issued_q <= 1'b0;
        end else if (grant_i) begin
            if ({1'b0, fifo_q} == cfg_i.oc_real - 3'd1) begin
                issued_q <= 1'b1;
            end else begin
                fifo_q <= fifo_q + 1'b1;
            end
        end
    end

    assign done_o = run_i && (no_work || issued_q);

endmodule

// File: src/ppu.sv
// ################################################
// Post-processing on the GLB write data. Scales by
// an arithmetic shift, clamps to int8, optional
// ReLU. Bypassed when need_ppu is low.
// ################################################

module ppu (
    input  logic [token_pkg::DATA_W-1:0] data_i,
    input  token_pkg::pass_cfg_t         cfg_i,
    output logic [token_pkg::DATA_W-1:0] data_o
);

    logic signed [token_pkg::DATA_W-1:0] shifted;
    logic signed [token_pkg::DATA_W-1:0] clamped;

    always_comb begin
        shifted = $signed(data_i) >>> cfg_i.scaling;
        if (shifted > token_pkg::Q_MAX) begin
            clamped = token_pkg::Q_MAX;
        end else if (shifted < token_pkg::Q_MIN) begin
            clamped = token_pkg::Q_MIN;
        end else begin
            clamped = shifted;
        end
        if (cfg_i.relu_en && (clamped < 0)) begin
            clamped = '0;  // relu
        end
    end

    assign data_o = cfg_i.need_ppu ? clamped : data_i;

endmodule

// File: src/token_engine.sv
// ################################################
// Token engine top, GLB side. Fetch and drain run
// side by side during a pass, the arbiter shares
// the GLB port and the PPU shapes write data.
// ################################################

module token_engine (
    input  logic                           clk,
    input  logic                           rst_n_i,

    // pass control
    input  logic                           pass_start_i,
    input  token_pkg::pass_cfg_t           cfg_i,
    output logic                           pass_done_o,

    // GLB port, read data one cycle after glb_read_o
    output logic                           glb_read_o,
    output logic [token_pkg::WEB_W-1:0]    glb_web_o,
    output logic [token_pkg::ADDR_W-1:0]   glb_addr_o,
    output logic [token_pkg::DATA_W-1:0]   glb_write_data_o,
    input  logic [token_pkg::DATA_W-1:0]   glb_read_data_i,

    // ifmap FIFOs
    input  token_pkg::fifo_mask_t          ifmap_full_i,  // almost full
    output token_pkg::push_t               ifmap_push_o,

    // opsum FIFOs
    input  token_pkg::fifo_mask_t          opsum_empty_i,
    input  logic [token_pkg::DATA_W-1:0]   opsum_pop_data_i [token_pkg::NUM_FIFO],
    output token_pkg::fifo_mask_t          opsum_pop_o
);

    logic                          run;
    logic                          fetch_done;
    logic                          drain_done;
    logic                          rd_grant;
    logic                          wr_grant;
    token_pkg::glb_req_t           rd_req;
    token_pkg::glb_req_t           wr_req;
    logic [token_pkg::DATA_W-1:0]  wr_data;  // before PPU

    engine_ctrl u_engine_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pass_start_i (pass_start_i),
        .fetch_done_i (fetch_done),
        .drain_done_i (drain_done),
        .run_o        (run),
        .pass_done_o  (pass_done_o)
    );

    ifmap_fetch u_ifmap_fetch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .run_i       (run),
        .cfg_i       (cfg_i),
        .full_i      (ifmap_full_i),
        .grant_i     (rd_grant),
        .read_data_i (glb_read_data_i),
        .req_o       (rd_req),
        .push_o      (ifmap_push_o),
        .done_o      (fetch_done)
    );

    opsum_drain u_opsum_drain (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .run_i      (run),
        .cfg_i      (cfg_i),
        .empty_i    (opsum_empty_i),
        .pop_data_i (opsum_pop_data_i),
        .grant_i    (wr_grant),
        .req_o      (wr_req),
        .pop_o      (opsum_pop_o),
        .done_o     (drain_done)
    );

    glb_arbiter u_glb_arbiter (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_req_i   (rd_req),
        .wr_req_i   (wr_req),
        .rd_grant_o (rd_grant),
        .wr_grant_o (wr_grant),
        .glb_read_o (glb_read_o),
        .glb_web_o  (glb_web_o),
        .glb_addr_o (glb_addr_o),
        .wr_data_o  (wr_data)
    );

    ppu u_ppu (
        .data_i (wr_data),
        .cfg_i  (cfg_i),
        .data_o (glb_write_data_o)
    );

endmodule

// File: src/token_pkg.sv
// ################################################
// Shared sizes, GLB port encodings and packed
// structs for the token engine and its testbench.
// Referenced by scoped names, no import.
// ################################################

package token_pkg;

    localparam int NUM_FIFO   = 4;   // ifmap and opsum FIFO count
    localparam int DATA_W     = 32;  // GLB word
    localparam int ADDR_W     = 32;
    localparam int WEB_W      = 4;
    localparam int FIFO_IDX_W = 2;

    // GLB byte write enable is active low
    localparam logic [WEB_W-1:0] WEB_IDLE = 4'b1111;
    localparam logic [WEB_W-1:0] WEB_WORD = 4'b0000;

    localparam int BYTE_SHIFT = 2;    // word to byte address

    // signed 8-bit output range of the PPU
    localparam int Q_MIN = -128;
    localparam int Q_MAX = 127;

    typedef logic [NUM_FIFO-1:0] fifo_mask_t;

    // settings of one pass, held stable while the pass runs
    typedef struct packed {
        logic [ADDR_W-1:0] ifmap_base;   // word address
        logic [ADDR_W-1:0] opsum_base;   // word address
        logic [7:0]        ifmap_words;  // words per ifmap FIFO
        logic [2:0]        ic_real;      // 0..4
        logic [2:0]        oc_real;      // 0..4
        logic [5:0]        scaling;      // arithmetic right shift
        logic              relu_en;
        logic              need_ppu;
    } pass_cfg_t;

    // request from one channel towards the arbiter
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;   // byte address
        logic [DATA_W-1:0] wdata;
    } glb_req_t;

    typedef struct packed {
        fifo_mask_t        push;
        logic [DATA_W-1:0] data;
    } push_t;

endpackage

// File: tb.f
src/token_pkg.sv
src/engine_ctrl.sv
src/ifmap_fetch.sv
src/opsum_drain.sv
src/glb_arbiter.sv
src/ppu.sv
src/token_engine.sv
dv/tb_clock.sv
dv/token_engine_checker.sv
dv/token_engine_tb.sv
